// File: rtl/sha_miner_pkg.sv
package sha_miner_pkg;

	typedef logic [31:0]  word_t;
	typedef logic [255:0] digest_t;
	typedef logic [511:0] block_t;
	typedef logic [31:0]  nonce_t;

	localparam int ROUNDS = 64;

	// From the issue register to the found register there are 64 + 1 + 64 + 1 cycles of hashing
	// plus the compare.
	localparam int PIPE_LATENCY = 131;

	localparam word_t SHA_K [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Word a sits in the top bits.
	localparam digest_t SHA_IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	typedef enum logic [1:0] {
		SWEEP_IDLE,
		SWEEP_RUN,
		SWEEP_DRAIN
	} sweep_state_t;

endpackage

// File: rtl/sha_round_stage.sv
`timescale 1ns/1ps

module sha_round_stage import sha_miner_pkg::*; #(
	parameter int ROUND = 0
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    valid_i,
	input  digest_t state_i,
	input  block_t  window_i,
	output logic    valid_o,
	output digest_t state_o,
	output block_t  window_o
);

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	word_t a, b, c, d, e, f, g, h;
	word_t win_0, win_1, win_9, win_14;
	word_t sig0, sig1, sum0, sum1, ch, maj;
	word_t w_round, t1, t2;

	assign {a, b, c, d, e, f, g, h} = state_i;

	// The window holds the last sixteen message words, oldest in word 0.
	assign win_0  = window_i[511 -: 32];
	assign win_1  = window_i[479 -: 32];
	assign win_9  = window_i[223 -: 32];
	assign win_14 = window_i[63 -: 32];

	assign sig0 = rotr(win_1, 7) ^ rotr(win_1, 18) ^ (win_1 >> 3);
	assign sig1 = rotr(win_14, 17) ^ rotr(win_14, 19) ^ (win_14 >> 10);

	// The first sixteen rounds take the block words as they are.
	// Later rounds expand the schedule from the window.
	assign w_round = (ROUND < 16) ? win_0 : (sig1 + win_9 + sig0 + win_0);

	assign sum0 = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
	assign sum1 = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);
	assign ch   = (e & f) ^ (~e & g);
	assign maj  = (a & b) ^ (a & c) ^ (b & c);

	assign t1 = h + sum1 + ch + SHA_K[ROUND] + w_round;
	assign t2 = sum0 + maj;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		state_o  <= {t1 + t2, a, b, c, d + t1, e, f, g};
		window_o <= {window_i[479:0], w_round};
	end

endmodule

// File: rtl/sha_compress_pipe.sv
`timescale 1ns/1ps

module sha_compress_pipe import sha_miner_pkg::*; #(
	parameter bit FROM_IV = 1'b0
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    valid_i,
	input  digest_t chain_i,
	input  block_t  block_i,
	output logic    valid_o,
	output digest_t digest_o
);

	logic    valid_pipe  [0:ROUNDS];
	digest_t state_pipe  [0:ROUNDS];
	block_t  window_pipe [0:ROUNDS];
	digest_t chain_in;
	digest_t chain_out;

	if (FROM_IV) begin : g_iv
		assign chain_in  = SHA_IV;
		assign chain_out = SHA_IV;
	end else begin : g_port
		digest_t chain_dly [0:ROUNDS-1];

		// Each job's chaining value walks beside its rounds, so back-to-back jobs stay apart.
		always_ff @(posedge clk) begin
			chain_dly[0] <= chain_i;
			for (int i = 1; i < ROUNDS; i++) begin
				chain_dly[i] <= chain_dly[i-1];
			end
		end

		assign chain_in  = chain_i;
		assign chain_out = chain_dly[ROUNDS-1];
	end

	assign valid_pipe[0]  = valid_i;
	assign state_pipe[0]  = chain_in;
	assign window_pipe[0] = block_i;

	for (genvar r = 0; r < ROUNDS; r++) begin : g_round
		sha_round_stage #(
			.ROUND(r)
		) u_stage (
			.clk      (clk),
			.rst_n_i  (rst_n_i),
			.valid_i  (valid_pipe[r]),
			.state_i  (state_pipe[r]),
			.window_i (window_pipe[r]),
			.valid_o  (valid_pipe[r+1]),
			.state_o  (state_pipe[r+1]),
			.window_o (window_pipe[r+1])
		);
	end

	// The feed-forward adds the chaining value word by word.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			digest_o[255-32*i -: 32] = state_pipe[ROUNDS][255-32*i -: 32] +
				chain_out[255-32*i -: 32];
		end
	end

	assign valid_o = valid_pipe[ROUNDS];

endmodule

// File: rtl/sha_double_hasher.sv
`timescale 1ns/1ps

module sha_double_hasher import sha_miner_pkg::*; (
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic         valid_i,
	input  nonce_t       nonce_i,
	input  digest_t      midstate_i,
	input  word_t [0:2]  tail_i,
	output logic         valid_o,
	output digest_t      digest_o
);

	word_t   nonce_swapped;
	block_t  header_block;
	logic    first_valid;
	digest_t first_digest;
	logic    pad_valid_q;
	block_t  pad_block_q;
	logic    final_valid;
	digest_t final_digest;

	// The header stores the nonce little endian, while SHA reads words big endian.
	assign nonce_swapped = {<<8{nonce_i}};

	// The second header block holds 16 bytes of data, then padding for a 640-bit message.
	assign header_block = {tail_i[0], tail_i[1], tail_i[2], nonce_swapped,
		32'h80000000, 320'd0, 32'd640};

	sha_compress_pipe #(
		.FROM_IV(1'b0)
	) u_first (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.valid_i  (valid_i),
		.chain_i  (midstate_i),
		.block_i  (header_block),
		.valid_o  (first_valid),
		.digest_o (first_digest)
	);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pad_valid_q <= 1'b0;
			valid_o     <= 1'b0;
		end else begin
			pad_valid_q <= first_valid;
			valid_o     <= final_valid;
		end
	end

	// The first digest becomes a single padded block of a 256-bit message.
	always_ff @(posedge clk) begin
		pad_block_q <= {first_digest, 32'h80000000, 192'd0, 32'd256};
		digest_o    <= final_digest;
	end

	sha_compress_pipe #(
		.FROM_IV(1'b1)
	) u_second (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.valid_i  (pad_valid_q),
		.chain_i  ('0),
		.block_i  (pad_block_q),
		.valid_o  (final_valid),
		.digest_o (final_digest)
	);

endmodule

// File: rtl/sha_nonce_sweeper.sv
`timescale 1ns/1ps

module sha_nonce_sweeper import sha_miner_pkg::*; (
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic         start_i,
	input  digest_t      midstate_i,
	input  word_t [0:2]  tail_i,
	input  digest_t      target_i,
	input  nonce_t       nonce_first_i,
	input  nonce_t       nonce_last_i,
	output logic         issue_valid_o,
	output nonce_t       issue_nonce_o,
	output digest_t      job_midstate_o,
	output word_t [0:2]  job_tail_o,
	output digest_t      job_target_o,
	output logic         busy_o,
	output logic         done_o
);

	sweep_state_t                      state_q;
	nonce_t                            nonce_last_q;
	logic [$clog2(PIPE_LATENCY)-1:0]   drain_cnt_q;
	logic                              accept;

	assign accept = (state_q == SWEEP_IDLE) && start_i;
	assign busy_o = (state_q != SWEEP_IDLE);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q       <= SWEEP_IDLE;
			issue_valid_o <= 1'b0;
			done_o        <= 1'b0;
			drain_cnt_q   <= '0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				SWEEP_IDLE: begin
					if (start_i) begin
						state_q       <= SWEEP_RUN;
						issue_valid_o <= 1'b1;
					end
				end
				SWEEP_RUN: begin
					if (issue_nonce_o == nonce_last_q) begin
						state_q       <= SWEEP_DRAIN;
						issue_valid_o <= 1'b0;
						drain_cnt_q   <= '0;
					end
				end
				SWEEP_DRAIN: begin
					// The count starts one cycle after the last issue, so stop at latency minus two.
					drain_cnt_q <= drain_cnt_q + 1'b1;
					if (drain_cnt_q == PIPE_LATENCY - 2) begin
						state_q <= SWEEP_IDLE;
						done_o  <= 1'b1;
					end
				end
				default: begin
					state_q <= SWEEP_IDLE;
				end
			endcase
		end
	end

	// Job registers hold still for the whole sweep.
	always_ff @(posedge clk) begin
		if (accept) begin
			job_midstate_o <= midstate_i;
			job_tail_o     <= tail_i;
			job_target_o   <= target_i;
			nonce_last_q   <= nonce_last_i;
			issue_nonce_o  <= nonce_first_i;
		end else if (state_q == SWEEP_RUN) begin
			issue_nonce_o <= issue_nonce_o + 1'b1;
		end
	end

endmodule

// File: rtl/sha_result_check.sv
`timescale 1ns/1ps

module sha_result_check import sha_miner_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  logic    issue_valid_i,
	input  nonce_t  issue_nonce_i,
	input  logic    digest_valid_i,
	input  digest_t digest_i,
	input  digest_t target_i,
	output logic    found_o,
	output nonce_t  found_nonce_o,
	output digest_t found_digest_o
);

	logic    valid_dly [0:PIPE_LATENCY-2];
	nonce_t  nonce_dly [0:PIPE_LATENCY-2];
	digest_t hash_value;
	logic    hit;

	// The nonce lines up with its digest after the hasher's 130 cycles.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < PIPE_LATENCY - 1; i++) begin
				valid_dly[i] <= 1'b0;
			end
		end else begin
			valid_dly[0] <= issue_valid_i;
			for (int i = 1; i < PIPE_LATENCY - 1; i++) begin
				valid_dly[i] <= valid_dly[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		nonce_dly[0] <= issue_nonce_i;
		for (int i = 1; i < PIPE_LATENCY - 1; i++) begin
			nonce_dly[i] <= nonce_dly[i-1];
		end
	end

	// Bitcoin compares the digest as a little-endian number.
	assign hash_value = {<<8{digest_i}};
	assign hit = digest_valid_i && valid_dly[PIPE_LATENCY-2] && (hash_value <= target_i);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			found_o <= 1'b0;
		end else begin
			found_o <= hit;
		end
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			found_nonce_o  <= nonce_dly[PIPE_LATENCY-2];
			found_digest_o <= digest_i;
		end
	end

endmodule

// File: rtl/sha_miner_top.sv
`timescale 1ns/1ps

module sha_miner_top import sha_miner_pkg::*; (
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic         start_i,
	input  digest_t      midstate_i,
	input  word_t [0:2]  tail_i,
	input  digest_t      target_i,
	input  nonce_t       nonce_first_i,
	input  nonce_t       nonce_last_i,
	output logic         found_o,
	output nonce_t       found_nonce_o,
	output digest_t      found_digest_o,
	output logic         busy_o,
	output logic         done_o
);

	logic        issue_valid;
	nonce_t      issue_nonce;
	digest_t     job_midstate;
	word_t [0:2] job_tail;
	digest_t     job_target;
	logic        digest_valid;
	digest_t     digest;

	sha_nonce_sweeper u_sweeper (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.start_i        (start_i),
		.midstate_i     (midstate_i),
		.tail_i         (tail_i),
		.target_i       (target_i),
		.nonce_first_i  (nonce_first_i),
		.nonce_last_i   (nonce_last_i),
		.issue_valid_o  (issue_valid),
		.issue_nonce_o  (issue_nonce),
		.job_midstate_o (job_midstate),
		.job_tail_o     (job_tail),
		.job_target_o   (job_target),
		.busy_o         (busy_o),
		.done_o         (done_o)
	);

	sha_double_hasher u_hasher (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.valid_i    (issue_valid),
		.nonce_i    (issue_nonce),
		.midstate_i (job_midstate),
		.tail_i     (job_tail),
		.valid_o    (digest_valid),
		.digest_o   (digest)
	);

	sha_result_check u_check (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.issue_valid_i  (issue_valid),
		.issue_nonce_i  (issue_nonce),
		.digest_valid_i (digest_valid),
		.digest_i       (digest),
		.target_i       (job_target),
		.found_o        (found_o),
		.found_nonce_o  (found_nonce_o),
		.found_digest_o (found_digest_o)
	);

endmodule

// File: verif/sha_miner_tb.sv
`timescale 1ns/1ps

module sha_miner_tb import sha_miner_pkg::*; ;

	logic        clk;
	logic        rst_n_i;
	logic        start_i;
	digest_t     midstate_i;
	word_t [0:2] tail_i;
	digest_t     target_i;
	nonce_t      nonce_first_i;
	nonce_t      nonce_last_i;
	logic        found_o;
	nonce_t      found_nonce_o;
	digest_t     found_digest_o;
	logic        busy_o;
	logic        done_o;

	// The job table keeps one entry per row in every queue.
	string       row_name [$];
	digest_t     row_midstate [$];
	word_t [0:2] row_tail [$];
	digest_t     row_target [$];
	nonce_t      row_first [$];
	nonce_t      row_last [$];
	int          row_hits [$];
	nonce_t      row_nonce [$];
	digest_t     row_digest [$];

	sha_miner_top uut (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.start_i        (start_i),
		.midstate_i     (midstate_i),
		.tail_i         (tail_i),
		.target_i       (target_i),
		.nonce_first_i  (nonce_first_i),
		.nonce_last_i   (nonce_last_i),
		.found_o        (found_o),
		.found_nonce_o  (found_nonce_o),
		.found_digest_o (found_digest_o),
		.busy_o         (busy_o),
		.done_o         (done_o)
	);

	always #2 clk = ~clk;

	function automatic word_t rotate_right(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Plain SHA-256 compression of one block, used to build the genesis midstate.
	function automatic digest_t compress_block(input digest_t chain, input block_t blk);
		word_t   w [0:63];
		word_t   v [0:7];
		word_t   s0, s1, t1, t2;
		digest_t result;
		for (int i = 0; i < 16; i++) begin
			w[i] = blk[511-32*i -: 32];
		end
		for (int i = 16; i < 64; i++) begin
			s0 = rotate_right(w[i-15], 7) ^ rotate_right(w[i-15], 18) ^ (w[i-15] >> 3);
			s1 = rotate_right(w[i-2], 17) ^ rotate_right(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = w[i-16] + s0 + w[i-7] + s1;
		end
		for (int i = 0; i < 8; i++) begin
			v[i] = chain[255-32*i -: 32];
		end
		for (int i = 0; i < 64; i++) begin
			s1 = rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[i] + w[i];
			s0 = rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int j = 7; j > 0; j--) begin
				v[j] = v[j-1];
			end
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++) begin
			result[255-32*i -: 32] = chain[255-32*i -: 32] + v[i];
		end
		return result;
	endfunction

	task automatic check_value(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic add_row(input string name, input digest_t mid, input word_t [0:2] tail,
		input digest_t target, input nonce_t first, input nonce_t last, input int hits,
		input nonce_t nonce, input digest_t digest);
		row_name.push_back(name);
		row_midstate.push_back(mid);
		row_tail.push_back(tail);
		row_target.push_back(target);
		row_first.push_back(first);
		row_last.push_back(last);
		row_hits.push_back(hits);
		row_nonce.push_back(nonce);
		row_digest.push_back(digest);
	endtask

	task automatic fill_table();
		digest_t     gen_mid;
		word_t [0:2] gen_tail;
		digest_t     gen_target;
		digest_t     gen_digest;
		// The first 64 header bytes hold the version, a zero previous hash and 28 bytes of
		// merkle root.
		gen_mid = compress_block(SHA_IV, {32'h01000000, 256'd0, 32'h3ba3edfd, 32'h7a7b12b2,
			32'h7ac72c3e, 32'h67768f61, 32'h7fc81bc3, 32'h888a5132, 32'h3a9fb8aa});
		gen_tail   = {32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d};
		gen_target = {32'h00000000, 32'hffff0000, 192'd0};
		gen_digest = 256'h6fe28c0ab6f1b372c1a6a246ae63f74f931e8365e15a089c68d6190000000000;
		add_row("genesis_hit", gen_mid, gen_tail, gen_target, 32'h7c2bac15, 32'h7c2bac24,
			1, 32'h7c2bac1d, gen_digest);
		add_row("all_ones", gen_mid, gen_tail, '1, 32'h7c2bac1a, 32'h7c2bac21,
			8, 32'h7c2bac1d, gen_digest);
		add_row("zero_target", gen_mid, gen_tail, '0, 32'h7c2bac15, 32'h7c2bac24, 0, '0, '0);
		add_row("other_midstate", SHA_IV, gen_tail, gen_target, 32'h7c2bac15, 32'h7c2bac24,
			0, '0, '0);
		add_row("single_nonce", gen_mid, gen_tail, gen_target, 32'h7c2bac1d, 32'h7c2bac1d,
			1, 32'h7c2bac1d, gen_digest);
	endtask

	task automatic run_row(input int r);
		int     n_nonces;
		int     hit_cyc;
		int     cyc;
		int     hits;
		int     gap;
		nonce_t exp_nonce;
		logic   prev_busy;
		logic   done_seen;
		n_nonces = row_last[r] - row_first[r] + 1;
		// The expected winner is issued at its offset from the first nonce.
		hit_cyc = PIPE_LATENCY + 1 + (row_nonce[r] - row_first[r]);
		cyc = 0;
		hits = 0;
		prev_busy = 1'b0;
		done_seen = 1'b0;
		@(posedge clk);
		midstate_i    <= row_midstate[r];
		tail_i        <= row_tail[r];
		target_i      <= row_target[r];
		nonce_first_i <= row_first[r];
		nonce_last_i  <= row_last[r];
		start_i       <= 1'b1;
		while (!done_seen) begin
			@(posedge clk);
			if (cyc == 0 || cyc == 4) begin
				start_i <= 1'b0;
			end else if (cyc == 3) begin
				// A second start while busy must not restart the sweep with this target.
				start_i       <= 1'b1;
				target_i      <= '1;
				nonce_first_i <= '0;
			end
			@(negedge clk);
			cyc++;
			if (cyc > n_nonces + PIPE_LATENCY + 20) begin
				$display("Timeout in %s: done_o never pulsed", row_name[r]);
				$display("Something failed");
				$fatal(1);
			end
			exp_nonce = row_first[r] + cyc - PIPE_LATENCY - 1;
			if (cyc == 3) begin
				check_value({row_name[r], "_busy_high"}, 1, busy_o);
			end
			if (found_o) begin
				hits++;
				check_value({row_name[r], "_hit_window"}, 1,
					(cyc > PIPE_LATENCY) && (cyc <= PIPE_LATENCY + n_nonces));
				check_value({row_name[r], "_hit_nonce"}, exp_nonce, found_nonce_o);
			end
			if (row_hits[r] > 0 && cyc == hit_cyc) begin
				check_value({row_name[r], "_hit_cycle"}, 1, found_o);
				check_value({row_name[r], "_digest"}, row_digest[r], found_digest_o);
			end
			if (done_o) begin
				done_seen = 1'b1;
				check_value({row_name[r], "_done_cycle"}, n_nonces + PIPE_LATENCY, cyc);
				check_value({row_name[r], "_busy_before_done"}, 1, prev_busy);
				check_value({row_name[r], "_busy_fall"}, 0, busy_o);
			end
			prev_busy = busy_o;
		end
		check_value({row_name[r], "_hit_count"}, row_hits[r], hits);
		// The pipeline stays quiet in the idle gap before the next job.
		gap = 1 + ($urandom % 4);
		repeat (gap) begin
			@(negedge clk);
			check_value({row_name[r], "_idle_busy"}, 0, busy_o);
			check_value({row_name[r], "_idle_found"}, 0, found_o);
			check_value({row_name[r], "_idle_done"}, 0, done_o);
		end
	endtask

	initial begin
		void'($urandom(36));
		clk           = 1'b0;
		rst_n_i       = 1'b0;
		start_i       = 1'b0;
		midstate_i    = '0;
		tail_i        = '0;
		target_i      = '0;
		nonce_first_i = '0;
		nonce_last_i  = '0;
		fill_table();
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		repeat (10) begin
			@(negedge clk);
			check_value("reset_found", 0, found_o);
			check_value("reset_done", 0, done_o);
			check_value("reset_busy", 0, busy_o);
		end
		for (int r = 0; r < row_name.size(); r++) begin
			run_row(r);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: sha_miner.f
rtl/sha_miner_pkg.sv
rtl/sha_round_stage.sv
rtl/sha_compress_pipe.sv
rtl/sha_double_hasher.sv
rtl/sha_nonce_sweeper.sv
rtl/sha_result_check.sv
rtl/sha_miner_top.sv
verif/sha_miner_tb.sv
